// File: cpu_pkg.sv
package cpu_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [3:0]  flags_t; // N V Z C

    localparam int FLAG_N = 3;
    localparam int FLAG_V = 2;
    localparam int FLAG_Z = 1;
    localparam int FLAG_C = 0;

    localparam flags_t MASK_NZ   = 4'b1010;
    localparam flags_t MASK_NZC  = 4'b1011;
    localparam flags_t MASK_NVZC = 4'b1111;

    localparam addr_t RESET_PC = 16'h0000;

    typedef enum logic [3:0] {
        ALU_PASS, ALU_ADC, ALU_SBC, ALU_AND,
        ALU_ORA,  ALU_EOR, ALU_CMP, ALU_ASL,
        ALU_LSR,  ALU_ROL, ALU_ROR, ALU_INC,
        ALU_DEC,  ALU_SEC, ALU_CLC, ALU_CLV
    } alu_op_t;

    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_Y
    } reg_sel_t;

    typedef enum logic [1:0] {
        S_FETCH,
        S_OPERAND,
        S_EXECUTE
    } state_t;

    localparam byte_t OP_LDA_IMM = 8'hA9;
    localparam byte_t OP_LDX_IMM = 8'hA2;
    localparam byte_t OP_LDY_IMM = 8'hA0;
    localparam byte_t OP_ADC_IMM = 8'h69;
    localparam byte_t OP_SBC_IMM = 8'hE9;
    localparam byte_t OP_AND_IMM = 8'h29;
    localparam byte_t OP_ORA_IMM = 8'h09;
    localparam byte_t OP_EOR_IMM = 8'h49;
    localparam byte_t OP_CMP_IMM = 8'hC9;
    localparam byte_t OP_CPX_IMM = 8'hE0;
    localparam byte_t OP_CPY_IMM = 8'hC0;
    localparam byte_t OP_ASL_A   = 8'h0A;
    localparam byte_t OP_LSR_A   = 8'h4A;
    localparam byte_t OP_ROL_A   = 8'h2A;
    localparam byte_t OP_ROR_A   = 8'h6A;
    localparam byte_t OP_TAX     = 8'hAA;
    localparam byte_t OP_TAY     = 8'hA8;
    localparam byte_t OP_TXA     = 8'h8A;
    localparam byte_t OP_TYA     = 8'h98;
    localparam byte_t OP_INX     = 8'hE8;
    localparam byte_t OP_INY     = 8'hC8;
    localparam byte_t OP_DEX     = 8'hCA;
    localparam byte_t OP_DEY     = 8'h88;
    localparam byte_t OP_SEC     = 8'h38;
    localparam byte_t OP_CLC     = 8'h18;
    localparam byte_t OP_CLV     = 8'hB8;
    localparam byte_t OP_NOP     = 8'hEA;
    localparam byte_t OP_BCS     = 8'hB0;
    localparam byte_t OP_BCC     = 8'h90;
    localparam byte_t OP_BEQ     = 8'hF0;
    localparam byte_t OP_BNE     = 8'hD0;
    localparam byte_t OP_BPL     = 8'h10;
    localparam byte_t OP_BMI     = 8'h30;

endpackage

// File: ctrl_if.sv
interface ctrl_if;
    import cpu_pkg::*;

    alu_op_t  alu_op;
    reg_sel_t src_sel;
    logic     use_operand; // Second ALU input is the immediate
    byte_t    operand;
    logic     reg_we;
    reg_sel_t dst_sel;
    flags_t   flag_we;

    modport decoder (
        output alu_op, src_sel, use_operand, operand,
        output reg_we, dst_sel, flag_we
    );

    modport datapath (
        input alu_op, src_sel, use_operand, operand,
        input reg_we, dst_sel, flag_we
    );

endinterface

// File: instruction_decode.sv
module instruction_decode (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::byte_t  instruction,
    input  cpu_pkg::flags_t flags,
    ctrl_if.decoder         ctrl,
    output logic            pc_inc,
    output logic            pc_branch,
    output logic            instr_done
);
    import cpu_pkg::*;

    state_t state;
    state_t next_state;
    byte_t  opcode;
    byte_t  operand;

    // Immediates and branches carry a second byte
    function automatic logic has_operand(byte_t op);
        case (op)
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM,
            OP_ADC_IMM, OP_SBC_IMM, OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM,
            OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM,
            OP_BCS, OP_BCC, OP_BEQ, OP_BNE, OP_BPL, OP_BMI: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    always_comb begin
        case (state)
            S_FETCH:   next_state = has_operand(instruction) ? S_OPERAND : S_EXECUTE;
            S_OPERAND: next_state = S_EXECUTE;
            default:   next_state = S_FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_FETCH;
            instr_done <= 1'b0;
        end else begin
            state      <= next_state;
            instr_done <= (state == S_EXECUTE); // Retire pulse
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH)
            opcode <= instruction;
        if (state == S_OPERAND)
            operand <= instruction;
    end

    assign pc_inc       = (state != S_EXECUTE);
    assign ctrl.operand = operand;

    always_comb begin
        ctrl.alu_op      = ALU_PASS;
        ctrl.src_sel     = REG_A;
        ctrl.use_operand = 1'b0;
        ctrl.reg_we      = 1'b0;
        ctrl.dst_sel     = REG_A;
        ctrl.flag_we     = '0;
        pc_branch        = 1'b0;
        if (state == S_EXECUTE) begin
            case (opcode)
                OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM: begin
                    ctrl.use_operand = 1'b1;
                    ctrl.reg_we      = 1'b1;
                    ctrl.dst_sel     = (opcode == OP_LDA_IMM) ? REG_A :
                                       (opcode == OP_LDX_IMM) ? REG_X : REG_Y;
                    ctrl.flag_we     = MASK_NZ;
                end
                OP_ADC_IMM, OP_SBC_IMM: begin
                    ctrl.alu_op      = (opcode == OP_ADC_IMM) ? ALU_ADC : ALU_SBC;
                    ctrl.use_operand = 1'b1;
                    ctrl.reg_we      = 1'b1;
                    ctrl.flag_we     = MASK_NVZC;
                end
                OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
                    ctrl.alu_op      = (opcode == OP_AND_IMM) ? ALU_AND :
                                       (opcode == OP_ORA_IMM) ? ALU_ORA : ALU_EOR;
                    ctrl.use_operand = 1'b1;
                    ctrl.reg_we      = 1'b1;
                    ctrl.flag_we     = MASK_NZ;
                end
                OP_CMP_IMM, OP_CPX_IMM, OP_CPY_IMM: begin
                    ctrl.alu_op      = ALU_CMP;
                    ctrl.src_sel     = (opcode == OP_CMP_IMM) ? REG_A :
                                       (opcode == OP_CPX_IMM) ? REG_X : REG_Y;
                    ctrl.use_operand = 1'b1;
                    ctrl.flag_we     = MASK_NZC;
                end
                OP_ASL_A, OP_LSR_A, OP_ROL_A, OP_ROR_A: begin
                    ctrl.alu_op  = (opcode == OP_ASL_A) ? ALU_ASL :
                                   (opcode == OP_LSR_A) ? ALU_LSR :
                                   (opcode == OP_ROL_A) ? ALU_ROL : ALU_ROR;
                    ctrl.reg_we  = 1'b1;
                    ctrl.flag_we = MASK_NZC;
                end
                OP_TAX, OP_TAY: begin
                    ctrl.reg_we  = 1'b1; // Flags left alone
                    ctrl.dst_sel = (opcode == OP_TAX) ? REG_X : REG_Y;
                end
                OP_TXA, OP_TYA: begin
                    ctrl.src_sel = (opcode == OP_TXA) ? REG_X : REG_Y;
                    ctrl.reg_we  = 1'b1;
                end
                OP_INX, OP_INY, OP_DEX, OP_DEY: begin
                    ctrl.alu_op  = (opcode == OP_INX || opcode == OP_INY) ? ALU_INC : ALU_DEC;
                    ctrl.src_sel = (opcode == OP_INX || opcode == OP_DEX) ? REG_X : REG_Y;
                    ctrl.dst_sel = ctrl.src_sel;
                    ctrl.reg_we  = 1'b1;
                    ctrl.flag_we = MASK_NZ;
                end
                OP_SEC, OP_CLC: begin
                    ctrl.alu_op          = (opcode == OP_SEC) ? ALU_SEC : ALU_CLC;
                    ctrl.flag_we[FLAG_C] = 1'b1;
                end
                OP_CLV: begin
                    ctrl.alu_op          = ALU_CLV;
                    ctrl.flag_we[FLAG_V] = 1'b1;
                end
                OP_BCS: pc_branch = flags[FLAG_C];
                OP_BCC: pc_branch = ~flags[FLAG_C];
                OP_BEQ: pc_branch = flags[FLAG_Z];
                OP_BNE: pc_branch = ~flags[FLAG_Z];
                OP_BPL: pc_branch = ~flags[FLAG_N];
                OP_BMI: pc_branch = flags[FLAG_N];
                default: ; // NOP and unknown opcodes
            endcase
        end
    end

endmodule

// File: alu.sv
module alu (
    ctrl_if.datapath        ctrl,
    input  cpu_pkg::byte_t  a_value,
    input  cpu_pkg::byte_t  src_value,
    input  cpu_pkg::flags_t flags,
    output cpu_pkg::byte_t  result,
    output cpu_pkg::flags_t next_flags
);
    import cpu_pkg::*;

    byte_t      b;
    byte_t      addend;
    logic [8:0] sum;
    logic [8:0] diff;
    logic       carry;
    logic       ovf;

    always_comb begin
        b      = ctrl.use_operand ? ctrl.operand : src_value;
        addend = (ctrl.alu_op == ALU_SBC) ? ~b : b;
        sum    = {1'b0, a_value} + {1'b0, addend} + {8'd0, flags[FLAG_C]};
        diff   = {1'b0, src_value} - {1'b0, ctrl.operand}; // Bit 8 is the borrow
        result = b;
        carry  = flags[FLAG_C];
        ovf    = flags[FLAG_V];
        case (ctrl.alu_op)
            ALU_ADC, ALU_SBC: begin
                result = sum[7:0];
                carry  = sum[8];
                ovf    = (a_value[7] == addend[7]) && (sum[7] != a_value[7]);
            end
            ALU_AND: result = a_value & b;
            ALU_ORA: result = a_value | b;
            ALU_EOR: result = a_value ^ b;
            ALU_CMP: begin
                result = diff[7:0];
                carry  = ~diff[8];
            end
            ALU_ASL: begin
                result = {a_value[6:0], 1'b0};
                carry  = a_value[7];
            end
            ALU_LSR: begin
                result = {1'b0, a_value[7:1]};
                carry  = a_value[0];
            end
            ALU_ROL: begin
                result = {a_value[6:0], flags[FLAG_C]};
                carry  = a_value[7];
            end
            ALU_ROR: begin
                result = {flags[FLAG_C], a_value[7:1]};
                carry  = a_value[0];
            end
            ALU_INC: result = b + 8'd1;
            ALU_DEC: result = b - 8'd1;
            ALU_SEC: carry  = 1'b1;
            ALU_CLC: carry  = 1'b0;
            ALU_CLV: ovf    = 1'b0;
            default: result = b; // Pass
        endcase
        next_flags[FLAG_N] = result[7];
        next_flags[FLAG_V] = ovf;
        next_flags[FLAG_Z] = (result == 8'd0);
        next_flags[FLAG_C] = carry;
    end

endmodule

// File: register_file.sv
module register_file (
    input  logic           clk,
    input  logic           rst_n,
    ctrl_if.datapath       ctrl,
    input  cpu_pkg::byte_t result,
    output cpu_pkg::byte_t a_value,
    output cpu_pkg::byte_t src_value,
    output cpu_pkg::byte_t reg_a,
    output cpu_pkg::byte_t reg_x,
    output cpu_pkg::byte_t reg_y
);
    import cpu_pkg::*;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_a <= '0;
            reg_x <= '0;
            reg_y <= '0;
        end else if (ctrl.reg_we) begin
            case (ctrl.dst_sel)
                REG_A:   reg_a <= result;
                REG_X:   reg_x <= result;
                default: reg_y <= result;
            endcase
        end
    end

    assign a_value = reg_a; // Fixed first ALU input

    always_comb begin
        case (ctrl.src_sel)
            REG_A:   src_value = reg_a;
            REG_X:   src_value = reg_x;
            default: src_value = reg_y;
        endcase
    end

endmodule

// File: status_register.sv
module status_register (
    input  logic            clk,
    input  logic            rst_n,
    ctrl_if.datapath        ctrl,
    input  cpu_pkg::flags_t next_flags,
    output cpu_pkg::flags_t flags
);

    // Only the bits selected by flag_we take the new value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flags <= '0;
        else
            flags <= (flags & ~ctrl.flag_we) | (next_flags & ctrl.flag_we);
    end

endmodule

// File: program_counter.sv
module program_counter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           pc_inc,
    input  logic           pc_branch,
    input  cpu_pkg::byte_t offset,
    output cpu_pkg::addr_t pc
);
    import cpu_pkg::*;

    addr_t offset_ext;

    assign offset_ext = {{8{offset[7]}}, offset}; // Signed displacement

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pc <= RESET_PC;
        else if (pc_branch)
            pc <= pc + offset_ext;
        else if (pc_inc)
            pc <= pc + 16'd1;
    end

endmodule

// File: cpu_core.sv
module cpu_core (
    input  logic            clk,
    input  logic            rst_n,
    input  cpu_pkg::byte_t  instruction,
    output cpu_pkg::addr_t  pc,
    output logic            instr_done,
    output cpu_pkg::byte_t  reg_a,
    output cpu_pkg::byte_t  reg_x,
    output cpu_pkg::byte_t  reg_y,
    output cpu_pkg::flags_t flags
);
    import cpu_pkg::*;

    byte_t  a_value;
    byte_t  src_value;
    byte_t  result;
    flags_t next_flags;
    logic   pc_inc;
    logic   pc_branch;

    ctrl_if ctrl_bus ();

    instruction_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .flags       (flags),
        .ctrl        (ctrl_bus.decoder),
        .pc_inc      (pc_inc),
        .pc_branch   (pc_branch),
        .instr_done  (instr_done)
    );

    alu u_alu (
        .ctrl       (ctrl_bus.datapath),
        .a_value    (a_value),
        .src_value  (src_value),
        .flags      (flags),
        .result     (result),
        .next_flags (next_flags)
    );

    register_file u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl_bus.datapath),
        .result    (result),
        .a_value   (a_value),
        .src_value (src_value),
        .reg_a     (reg_a),
        .reg_x     (reg_x),
        .reg_y     (reg_y)
    );

    status_register u_status (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl_bus.datapath),
        .next_flags (next_flags),
        .flags      (flags)
    );

    program_counter u_pc (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_inc    (pc_inc),
        .pc_branch (pc_branch),
        .offset    (ctrl_bus.operand), // Branch displacement
        .pc        (pc)
    );

endmodule

// File: tb_cpu_core.sv
module tb_cpu_core;
    import cpu_pkg::*;

    typedef struct packed {
        byte_t     op;
        byte_t     opnd;
        byte_t     a, x, y;
        flags_t    f;
        addr_t     pc;
        logic [1:0] cyc;
    } row_t;

    localparam int N_FIXED = 52;
    localparam int N_RAND  = 6;
    localparam int WATCHDOG_CYCLES = (N_FIXED + 4 * N_RAND) * 3 + 20;

    // opcode, operand, A, X, Y, NVZC, pc after retire, cycles
    localparam row_t FIXED_ROWS [N_FIXED] = '{
        '{OP_LDA_IMM, 8'h80, 8'h80, 8'h00, 8'h00, 4'b1000, 16'h0002, 2'd3},
        '{OP_LDX_IMM, 8'h00, 8'h80, 8'h00, 8'h00, 4'b0010, 16'h0004, 2'd3},
        '{OP_TAX,     8'h00, 8'h80, 8'h80, 8'h00, 4'b0010, 16'h0005, 2'd2}, // Flags kept
        '{OP_LDY_IMM, 8'h05, 8'h80, 8'h80, 8'h05, 4'b0000, 16'h0007, 2'd3},
        '{OP_TYA,     8'h00, 8'h05, 8'h80, 8'h05, 4'b0000, 16'h0008, 2'd2},
        '{OP_TXA,     8'h00, 8'h80, 8'h80, 8'h05, 4'b0000, 16'h0009, 2'd2},
        '{OP_TAY,     8'h00, 8'h80, 8'h80, 8'h80, 4'b0000, 16'h000A, 2'd2},
        '{OP_ADC_IMM, 8'h80, 8'h00, 8'h80, 8'h80, 4'b0111, 16'h000C, 2'd3}, // -128 + -128
        '{OP_ADC_IMM, 8'h7F, 8'h80, 8'h80, 8'h80, 4'b1100, 16'h000E, 2'd3},
        '{OP_SBC_IMM, 8'h01, 8'h7E, 8'h80, 8'h80, 4'b0101, 16'h0010, 2'd3},
        '{OP_SBC_IMM, 8'h7E, 8'h00, 8'h80, 8'h80, 4'b0011, 16'h0012, 2'd3},
        '{OP_SBC_IMM, 8'h01, 8'hFF, 8'h80, 8'h80, 4'b1000, 16'h0014, 2'd3}, // Borrow out
        '{OP_AND_IMM, 8'h0F, 8'h0F, 8'h80, 8'h80, 4'b0000, 16'h0016, 2'd3},
        '{OP_ORA_IMM, 8'hF0, 8'hFF, 8'h80, 8'h80, 4'b1000, 16'h0018, 2'd3},
        '{OP_EOR_IMM, 8'hFF, 8'h00, 8'h80, 8'h80, 4'b0010, 16'h001A, 2'd3},
        '{OP_EOR_IMM, 8'hC1, 8'hC1, 8'h80, 8'h80, 4'b1000, 16'h001C, 2'd3},
        '{OP_ASL_A,   8'h00, 8'h82, 8'h80, 8'h80, 4'b1001, 16'h001D, 2'd2},
        '{OP_ROL_A,   8'h00, 8'h05, 8'h80, 8'h80, 4'b0001, 16'h001E, 2'd2}, // Old C enters bit 0
        '{OP_ROR_A,   8'h00, 8'h82, 8'h80, 8'h80, 4'b1001, 16'h001F, 2'd2},
        '{OP_LSR_A,   8'h00, 8'h41, 8'h80, 8'h80, 4'b0000, 16'h0020, 2'd2},
        '{OP_ROR_A,   8'h00, 8'h20, 8'h80, 8'h80, 4'b0001, 16'h0021, 2'd2},
        '{OP_LDX_IMM, 8'hFF, 8'h20, 8'hFF, 8'h80, 4'b1001, 16'h0023, 2'd3},
        '{OP_INX,     8'h00, 8'h20, 8'h00, 8'h80, 4'b0011, 16'h0024, 2'd2}, // Wraps to zero
        '{OP_DEX,     8'h00, 8'h20, 8'hFF, 8'h80, 4'b1001, 16'h0025, 2'd2},
        '{OP_DEY,     8'h00, 8'h20, 8'hFF, 8'h7F, 4'b0001, 16'h0026, 2'd2},
        '{OP_LDY_IMM, 8'h00, 8'h20, 8'hFF, 8'h00, 4'b0011, 16'h0028, 2'd3},
        '{OP_DEY,     8'h00, 8'h20, 8'hFF, 8'hFF, 4'b1001, 16'h0029, 2'd2},
        '{OP_INY,     8'h00, 8'h20, 8'hFF, 8'h00, 4'b0011, 16'h002A, 2'd2},
        '{OP_CMP_IMM, 8'h20, 8'h20, 8'hFF, 8'h00, 4'b0011, 16'h002C, 2'd3},
        '{OP_CMP_IMM, 8'h21, 8'h20, 8'hFF, 8'h00, 4'b1000, 16'h002E, 2'd3},
        '{OP_CPX_IMM, 8'hFE, 8'h20, 8'hFF, 8'h00, 4'b0001, 16'h0030, 2'd3},
        '{OP_CPY_IMM, 8'h01, 8'h20, 8'hFF, 8'h00, 4'b1000, 16'h0032, 2'd3},
        '{OP_CPY_IMM, 8'h00, 8'h20, 8'hFF, 8'h00, 4'b0011, 16'h0034, 2'd3},
        '{OP_CLC,     8'h00, 8'h20, 8'hFF, 8'h00, 4'b0010, 16'h0035, 2'd2},
        '{OP_SEC,     8'h00, 8'h20, 8'hFF, 8'h00, 4'b0011, 16'h0036, 2'd2},
        '{OP_ADC_IMM, 8'h5F, 8'h80, 8'hFF, 8'h00, 4'b1100, 16'h0038, 2'd3},
        '{OP_CLV,     8'h00, 8'h80, 8'hFF, 8'h00, 4'b1000, 16'h0039, 2'd2},
        '{OP_NOP,     8'h00, 8'h80, 8'hFF, 8'h00, 4'b1000, 16'h003A, 2'd2},
        '{OP_BMI,     8'h40, 8'h80, 8'hFF, 8'h00, 4'b1000, 16'h007C, 2'd3}, // Skips a gap
        '{OP_BPL,     8'hF0, 8'h80, 8'hFF, 8'h00, 4'b1000, 16'h007E, 2'd3},
        '{OP_BCC,     8'hE0, 8'h80, 8'hFF, 8'h00, 4'b1000, 16'h0060, 2'd3}, // Back into the gap
        '{OP_BCS,     8'h10, 8'h80, 8'hFF, 8'h00, 4'b1000, 16'h0062, 2'd3},
        '{OP_BNE,     8'h30, 8'h80, 8'hFF, 8'h00, 4'b1000, 16'h0094, 2'd3},
        '{OP_BEQ,     8'h80, 8'h80, 8'hFF, 8'h00, 4'b1000, 16'h0096, 2'd3},
        '{OP_LDA_IMM, 8'h00, 8'h00, 8'hFF, 8'h00, 4'b0010, 16'h0098, 2'd3},
        '{OP_SEC,     8'h00, 8'h00, 8'hFF, 8'h00, 4'b0011, 16'h0099, 2'd2},
        '{OP_BEQ,     8'hD0, 8'h00, 8'hFF, 8'h00, 4'b0011, 16'h006B, 2'd3},
        '{OP_BCS,     8'hF8, 8'h00, 8'hFF, 8'h00, 4'b0011, 16'h0065, 2'd3},
        '{OP_BPL,     8'h40, 8'h00, 8'hFF, 8'h00, 4'b0011, 16'h00A7, 2'd3},
        '{OP_BMI,     8'h10, 8'h00, 8'hFF, 8'h00, 4'b0011, 16'h00A9, 2'd3},
        '{OP_BNE,     8'h10, 8'h00, 8'hFF, 8'h00, 4'b0011, 16'h00AB, 2'd3},
        '{OP_BCC,     8'h10, 8'h00, 8'hFF, 8'h00, 4'b0011, 16'h00AD, 2'd3}
    };

    logic   clk;
    logic   rst_n;
    byte_t  instruction;
    addr_t  pc;
    logic   instr_done;
    byte_t  reg_a;
    byte_t  reg_x;
    byte_t  reg_y;
    flags_t flags;

    byte_t rom [65536];
    row_t  rows [$];

    assign instruction = rom[pc]; // Program memory answers in the same cycle

    cpu_core UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .pc          (pc),
        .instr_done  (instr_done),
        .reg_a       (reg_a),
        .reg_x       (reg_x),
        .reg_y       (reg_y),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the core stopped retiring instructions");
        $display("Simulation failed");
        $fatal(1);
    end

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // Reference model for the random immediates, working from the previous row's state
    task automatic predict_imm(input byte_t op, input byte_t opnd);
        row_t       r;
        byte_t      res;
        logic [8:0] u;
        int         s;
        r      = rows[rows.size() - 1];
        r.op   = op;
        r.opnd = opnd;
        r.pc   = r.pc + 16'd2;
        r.cyc  = 2'd3;
        case (op)
            OP_LDA_IMM: r.a = opnd;
            OP_ADC_IMM: begin
                u = 9'(r.a) + 9'(opnd) + 9'(r.f[FLAG_C]);
                s = int'($signed(r.a)) + int'($signed(opnd)) + int'(r.f[FLAG_C]);
                r.f[FLAG_V] = (s > 127) || (s < -128); // Signed range exceeded
                r.f[FLAG_C] = u[8];
                r.a = u[7:0];
            end
            OP_EOR_IMM: r.a = r.a ^ opnd;
            default: r.f[FLAG_C] = (r.a >= opnd);
        endcase
        res = (op == OP_CMP_IMM) ? r.a - opnd : r.a;
        r.f[FLAG_N] = res[7];
        r.f[FLAG_Z] = (res == 8'h00);
        rows.push_back(r);
    endtask

    initial begin
        int    count;
        addr_t addr;
        rst_n = 1'b0;
        void'($urandom(38792));
        for (int i = 0; i < N_FIXED; i++)
            rows.push_back(FIXED_ROWS[i]);
        for (int i = 0; i < N_RAND; i++) begin
            predict_imm(OP_LDA_IMM, 8'($urandom()));
            predict_imm(OP_ADC_IMM, 8'($urandom()));
            predict_imm(OP_EOR_IMM, 8'($urandom()));
            predict_imm(OP_CMP_IMM, 8'($urandom()));
        end
        for (int i = 0; i < 65536; i++)
            rom[16'(i)] = 8'(i) ^ 8'(i >> 8) ^ 8'hA5;
        addr = RESET_PC;
        foreach (rows[i]) begin
            rom[addr] = rows[i].op;
            if (rows[i].cyc == 2'd3)
                rom[addr + 16'd1] = rows[i].opnd;
            addr = rows[i].pc; // Next row starts where this one retires
        end

        repeat (3) @(posedge clk);
        #10 rst_n = 1'b1;
        @(negedge clk);
        check("pc after reset", pc, RESET_PC);
        check("instr_done after reset", 16'(instr_done), 16'h0000);
        check("reg_a after reset", 16'(reg_a), 16'h0000);
        check("reg_x after reset", 16'(reg_x), 16'h0000);
        check("reg_y after reset", 16'(reg_y), 16'h0000);
        check("flags after reset", 16'(flags), 16'h0000);

        foreach (rows[i]) begin
            count = 0;
            do begin
                @(negedge clk);
                count++;
            end while (!instr_done);
            check($sformatf("instr_done spacing (row %0d)", i), 16'(count), 16'(rows[i].cyc));
            check($sformatf("pc (row %0d)", i), pc, rows[i].pc);
            check($sformatf("reg_a (row %0d)", i), 16'(reg_a), 16'(rows[i].a));
            check($sformatf("reg_x (row %0d)", i), 16'(reg_x), 16'(rows[i].x));
            check($sformatf("reg_y (row %0d)", i), 16'(reg_y), 16'(rows[i].y));
            check($sformatf("flags (row %0d)", i), 16'(flags), 16'(rows[i].f));
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: sim.f
cpu_pkg.sv
ctrl_if.sv
instruction_decode.sv
alu.sv
register_file.sv
status_register.sv
program_counter.sv
cpu_core.sv
tb_cpu_core.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sim.f --top-module tb_cpu_core
output=$(./obj_dir/Vtb_cpu_core 2>&1) || true
echo "$output"
if grep -qx "Simulation completed successfully" <<< "$output"; then
    echo "PASS"
else
    echo "FAIL"
    exit 1
fi
